// ==== project.f ====
+incdir+logic
+incdir+verification
logic/execPkg.sv
logic/operandIf.sv
logic/resultIf.sv
logic/instrDecoder.sv
logic/registerFile.sv
logic/aluCore.sv
logic/writebackUnit.sv
logic/execTop.sv
verification/execTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the execTop testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module execTb -f project.f -o execSim \
  && ./obj_dir/execSim | tee /dev/stderr | grep -qF '*** PASSED ***' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== verification/execModel.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Architectural state as seen by the tests
logic [31:0] modelRegs [16];
logic [3:0] modelFlags;

function automatic void modelReset();
  for (int i = 0; i < 16; i++)
  begin
    modelRegs[i] = 32'd0;
  end
  modelFlags = 4'd0;
endfunction

function automatic void modelAdd(input logic [31:0] x, input logic [31:0] y, input logic ci,
                                 output logic [31:0] r, output logic c, output logic v);
  logic [32:0] wide;
  wide = {1'b0, x} + {1'b0, y} + {32'd0, ci};
  r = wide[31:0];
  c = wide[32];
  v = (x[31] == y[31]) && (r[31] != x[31]);
endfunction

// x - y - !ci, with C set when nothing is borrowed
function automatic void modelSub(input logic [31:0] x, input logic [31:0] y, input logic ci,
                                 output logic [31:0] r, output logic c, output logic v);
  r = x - y - {31'd0, ~ci};
  c = ({1'b0, x} >= ({1'b0, y} + {32'd0, ~ci}));
  v = (x[31] != y[31]) && (r[31] != x[31]);
endfunction

// Retires one word in the model, returns 0 for a class that is not executed
function automatic logic modelStep(input logic [31:0] word, output logic [31:0] value,
                                   output logic [3:0] dest, output logic writes,
                                   output logic [3:0] flagsOut);
  logic [2:0] cls;
  logic [3:0] op;
  logic [31:0] a;
  logic [31:0] b;
  logic c;
  logic v;
  cls = word[27:25];
  op = word[24:21];
  dest = word[15:12];
  value = 32'd0;
  writes = 1'b0;
  flagsOut = modelFlags;
  if (cls > 3'b001)
  begin
    return 1'b0;
  end
  a = modelRegs[word[19:16]];
  b = cls[0] ? {24'd0, word[7:0]} : modelRegs[word[3:0]];
  // Logical ops keep C and clear V
  c = modelFlags[1];
  v = 1'b0;
  case (op)
    4'd0, 4'd8: value = a & b;
    4'd1, 4'd9: value = a ^ b;
    4'd2, 4'd10: modelSub(a, b, 1'b1, value, c, v);
    4'd3: modelSub(b, a, 1'b1, value, c, v);
    4'd4, 4'd11: modelAdd(a, b, 1'b0, value, c, v);
    4'd5: modelAdd(a, b, modelFlags[1], value, c, v);
    4'd6: modelSub(a, b, modelFlags[1], value, c, v);
    4'd7: modelSub(b, a, modelFlags[1], value, c, v);
    4'd12: value = a | b;
    4'd13: value = b;
    4'd14: value = a & ~b;
    default: value = ~b;
  endcase
  // TST, TEQ, CMP and CMN only set flags
  writes = (op[3:2] != 2'b10);
  flagsOut = {value[31], value == 32'd0, c, v};
  if (writes)
  begin
    modelRegs[dest] = value;
  end
  modelFlags = flagsOut;
  return 1'b1;
endfunction

`endif

// ==== verification/execTb.sv ====
`timescale 1ns/1ps
`include "exec_settings.svh"

module execTb;
  import execPkg::*;

  localparam int loadLen = 28;
  localparam int logicRounds = 3;
  localparam int pairCount = 7;
  // Instructions issued over all tests
  localparam int instrTotal = 17 + loadLen + logicRounds * (2 * loadLen + 10) +
                              pairCount * (2 * loadLen + 6) + (2 * loadLen + 16) + 11 + 8;

  logic clk;
  logic rstN;
  logic instrValid;
  logic [31:0] instr;
  logic resultValid;
  logic [`DATA_WIDTH-1:0] result;
  logic [`REG_ADDR_WIDTH-1:0] resultReg;
  logic resultWritten;
  logic [3:0] flags;

  int seed = 32'h37c;
  int errorCount = 0;
  int testErrors = 0;
  int testCount = 0;
  int checkCount = 0;
  logic [31:0] burstWords [$];

  `include "execModel.svh"

  execTop dut_i (
    .clk(clk),
    .rstN(rstN),
    .instrValid(instrValid),
    .instr(instr),
    .resultValid(resultValid),
    .result(result),
    .resultReg(resultReg),
    .resultWritten(resultWritten),
    .flags(flags)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial
  begin
    #(instrTotal * 4 * 100 + 2000);
    $display("Timeout: the tests did not finish in the expected time");
    $display("*** FAILED ***");
    $finish;
  end

  task automatic reportMismatch(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
    $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
    errorCount++;
    testErrors++;
  endtask

  task automatic reportFailure(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errorCount++;
    testErrors++;
  endtask

  task automatic finishTest(input string name);
    $display("Test %-10s %s, %0d errors", name, (testErrors == 0) ? "ok" : "failed", testErrors);
    testErrors = 0;
    testCount++;
  endtask

  function automatic logic [31:0] encodeImm(input aluOp_t op, input logic [3:0] rn,
                                            input logic [3:0] rd, input logic [7:0] imm);
    return {4'he, 3'b001, op, 1'b1, rn, rd, 4'h0, imm};
  endfunction

  function automatic logic [31:0] encodeReg(input aluOp_t op, input logic [3:0] rn,
                                            input logic [3:0] rd, input logic [3:0] rm);
    return {4'he, 3'b000, op, 1'b1, rn, rd, 8'h00, rm};
  endfunction

  task automatic compareOutputs(input logic [31:0] expValue, input logic [3:0] expDest,
                                input logic expWrites, input logic [3:0] expFlags);
    if (result !== expValue)
      reportMismatch("result", result, expValue);
    if (resultReg !== expDest)
      reportMismatch("resultReg", {28'd0, resultReg}, {28'd0, expDest});
    if (resultWritten !== expWrites)
      reportMismatch("resultWritten", {31'd0, resultWritten}, {31'd0, expWrites});
    if (flags !== expFlags)
      reportMismatch("flags", {28'd0, flags}, {28'd0, expFlags});
  endtask

  // One word, then wait for its result with a bounded wait
  task automatic runOne(input logic [31:0] word);
    logic legal;
    logic [31:0] expValue;
    logic [3:0] expDest;
    logic expWrites;
    logic [3:0] expFlags;
    int waited;
    legal = modelStep(word, expValue, expDest, expWrites, expFlags);
    @(negedge clk);
    instrValid = 1'b1;
    instr = word;
    waited = 0;
    do
    begin
      @(negedge clk);
      instrValid = 1'b0;
      waited++;
    end
    while (!resultValid && waited < `RESULT_LATENCY + 2);
    checkCount++;
    if (!legal)
    begin
      if (resultValid)
        reportFailure($sformatf("illegal word %h produced a result", word));
      return;
    end
    if (!resultValid)
    begin
      reportFailure($sformatf("no result for word %h within %0d cycles", word, waited));
      return;
    end
    if (waited != `RESULT_LATENCY)
      reportMismatch("latency", waited, `RESULT_LATENCY);
    compareOutputs(expValue, expDest, expWrites, expFlags);
  endtask

  // Word k is strobed in slot k and is due in slot k + latency
  task automatic runBurst();
    logic [31:0] expValue [16];
    logic [3:0] expDest [16];
    logic expWrites [16];
    logic [3:0] expFlags [16];
    int n;
    n = burstWords.size();
    for (int k = 0; k < n; k++)
    begin
      void'(modelStep(burstWords[k], expValue[k], expDest[k], expWrites[k], expFlags[k]));
    end
    for (int i = 0; i < n + `RESULT_LATENCY; i++)
    begin
      @(negedge clk);
      if (i >= `RESULT_LATENCY)
      begin
        checkCount++;
        if (!resultValid)
          reportFailure($sformatf("burst result %0d missing in its slot", i - `RESULT_LATENCY));
        else
          compareOutputs(expValue[i - `RESULT_LATENCY], expDest[i - `RESULT_LATENCY],
                         expWrites[i - `RESULT_LATENCY], expFlags[i - `RESULT_LATENCY]);
      end
      else if (resultValid)
        reportFailure("result seen before the first burst word could retire");
      instrValid = (i < n);
      if (i < n)
        instr = burstWords[i];
    end
  endtask

  // Byte by byte, doubling eight times in between
  task automatic loadValue(input logic [3:0] rd, input logic [31:0] value);
    runOne(encodeImm(OP_MOV, 4'd0, rd, value[31:24]));
    for (int k = 2; k >= 0; k--)
    begin
      repeat (8)
      begin
        runOne(encodeReg(OP_ADD, rd, rd, rd));
      end
      runOne(encodeImm(OP_ORR, rd, rd, value[k * 8 +: 8]));
    end
  endtask

  task automatic resetAndMovTest();
    logic [31:0] rnd;
    logic [7:0] imm;
    repeat (3)
    begin
      @(negedge clk);
      checkCount++;
      if (resultValid || resultWritten)
        reportFailure("result strobes active right after reset");
    end
    if (flags !== 4'd0)
      reportMismatch("flags after reset", {28'd0, flags}, 32'd0);
    // Two cleared registers give zero and set Z
    runOne(encodeReg(OP_TEQ, 4'd7, 4'd0, 4'd9));
    for (int r = 0; r < 16; r++)
    begin
      rnd = $random(seed);
      imm = (r == 0) ? 8'd0 : rnd[7:0];
      runOne(encodeImm(OP_MOV, 4'd0, 4'(r), imm));
    end
    finishTest("movImm");
  endtask

  task automatic logicalTest();
    aluOp_t logicOps [5];
    logicOps = '{OP_AND, OP_EOR, OP_ORR, OP_BIC, OP_MVN};
    // Sign bit alone, so that a compare can leave V set
    loadValue(4'd15, 32'h80000000);
    repeat (logicRounds)
    begin
      loadValue(4'd1, $random(seed));
      loadValue(4'd2, $random(seed));
      for (int k = 0; k < 5; k++)
      begin
        // V set before each op, C alternating
        if (k % 2 == 0)
          runOne(encodeImm(OP_CMP, 4'd15, 4'd0, 8'h01));
        else
          runOne(encodeImm(OP_RSB, 4'd15, 4'd14, 8'h00));
        runOne(encodeReg(logicOps[k], 4'd1, 4'(k + 3), 4'd2));
      end
    end
    finishTest("logical");
  endtask

  task automatic arithmeticTest();
    logic [31:0] xs [pairCount];
    logic [31:0] ys [pairCount];
    // Sign boundaries, zero and a full carry
    xs[0] = 32'h7fffffff;
    ys[0] = 32'h00000001;
    xs[1] = 32'h80000000;
    ys[1] = 32'h00000001;
    xs[2] = 32'h00000000;
    ys[2] = 32'h00000000;
    xs[3] = 32'hffffffff;
    ys[3] = 32'h00000001;
    for (int k = 4; k < pairCount; k++)
    begin
      xs[k] = $random(seed);
      ys[k] = $random(seed);
    end
    for (int k = 0; k < pairCount; k++)
    begin
      loadValue(4'd4, xs[k]);
      loadValue(4'd5, ys[k]);
      // Each carry user follows the op whose carry it takes
      runOne(encodeReg(OP_ADD, 4'd4, 4'd6, 4'd5));
      runOne(encodeReg(OP_ADC, 4'd4, 4'd7, 4'd5));
      runOne(encodeReg(OP_SUB, 4'd4, 4'd6, 4'd5));
      runOne(encodeReg(OP_SBC, 4'd4, 4'd7, 4'd5));
      runOne(encodeReg(OP_RSB, 4'd4, 4'd6, 4'd5));
      runOne(encodeReg(OP_RSC, 4'd4, 4'd7, 4'd5));
    end
    finishTest("arithmetic");
  endtask

  task automatic compareTest();
    aluOp_t cmpOps [4];
    cmpOps = '{OP_TST, OP_TEQ, OP_CMP, OP_CMN};
    loadValue(4'd8, $random(seed));
    loadValue(4'd9, $random(seed));
    for (int k = 0; k < 4; k++)
    begin
      runOne(encodeImm(OP_MOV, 4'd0, 4'd10, 8'h5a));
      runOne(encodeReg(cmpOps[k], 4'd8, 4'd10, 4'd9));
      // Equal operands
      runOne(encodeReg(cmpOps[k], 4'd8, 4'd10, 4'd8));
      runOne(encodeReg(OP_MOV, 4'd0, 4'd11, 4'd10));
      checkCount++;
      if (result !== 32'h5a)
        reportMismatch("r10 after compare", result, 32'h5a);
    end
    finishTest("compare");
  endtask

  task automatic burstTest();
    burstWords.delete();
    burstWords.push_back(encodeImm(OP_MOV, 4'd0, 4'd1, 8'hf0));
    burstWords.push_back(encodeReg(OP_ADD, 4'd1, 4'd2, 4'd1));
    burstWords.push_back(encodeReg(OP_ADD, 4'd2, 4'd3, 4'd1));
    burstWords.push_back(encodeImm(OP_MVN, 4'd0, 4'd5, 8'h00));
    // Carry out of this ADD feeds the ADC behind it
    burstWords.push_back(encodeReg(OP_ADD, 4'd5, 4'd6, 4'd5));
    burstWords.push_back(encodeReg(OP_ADC, 4'd6, 4'd7, 4'd3));
    burstWords.push_back(encodeReg(OP_SUB, 4'd7, 4'd8, 4'd6));
    burstWords.push_back(encodeReg(OP_SBC, 4'd8, 4'd9, 4'd7));
    burstWords.push_back(encodeReg(OP_CMP, 4'd9, 4'd0, 4'd8));
    burstWords.push_back(encodeReg(OP_RSC, 4'd9, 4'd10, 4'd9));
    burstWords.push_back(encodeReg(OP_EOR, 4'd10, 4'd11, 4'd10));
    runBurst();
    finishTest("burst");
  endtask

  task automatic illegalClassTest();
    logic [2:0] cls;
    runOne(encodeImm(OP_MOV, 4'd0, 4'd12, 8'h33));
    for (int k = 2; k < 8; k++)
    begin
      cls = 3'(k);
      runOne({4'he, cls, OP_MOV, 1'b1, 4'd0, 4'd12, 4'h0, 8'hcc});
    end
    runOne(encodeReg(OP_MOV, 4'd0, 4'd13, 4'd12));
    checkCount++;
    if (result !== 32'h33)
      reportMismatch("r12 after illegal words", result, 32'h33);
    finishTest("illegal");
  endtask

  initial
  begin
    rstN = 1'b0;
    instrValid = 1'b0;
    instr = 32'd0;
    modelReset();
    repeat (5)
    begin
      @(negedge clk);
    end
    rstN = 1'b1;
    resetAndMovTest();
    logicalTest();
    arithmeticTest();
    compareTest();
    burstTest();
    illegalClassTest();
    $display("Totals: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== logic/execTop.sv ====
`timescale 1ns/1ps
`include "exec_settings.svh"

module execTop (
  input logic clk,
  input logic rstN,
  input logic instrValid,
  input logic [31:0] instr,
  output logic resultValid,
  output logic [`DATA_WIDTH-1:0] result,
  output logic [`REG_ADDR_WIDTH-1:0] resultReg,
  output logic resultWritten,
  output logic [3:0] flags
);

  logic [`REG_ADDR_WIDTH-1:0] readAddrA;
  logic [`REG_ADDR_WIDTH-1:0] readAddrB;
  logic [`DATA_WIDTH-1:0] readDataA;
  logic [`DATA_WIDTH-1:0] readDataB;
  logic writeEn;
  logic [`REG_ADDR_WIDTH-1:0] writeAddr;
  logic [`DATA_WIDTH-1:0] writeData;
  logic carryFlag;

  operandIf issuedBus ();
  resultIf outcomeBus ();

  instrDecoder decoder_i (
    .clk(clk),
    .rstN(rstN),
    .instrValid(instrValid),
    .instr(instr),
    .readAddrA(readAddrA),
    .readAddrB(readAddrB),
    .readDataA(readDataA),
    .readDataB(readDataB),
    .carryFlag(carryFlag),
    .issued(issuedBus.issue),
    .inFlight(outcomeBus.forward)
  );

  registerFile regFile_i (
    .clk(clk),
    .rstN(rstN),
    .readAddrA(readAddrA),
    .readAddrB(readAddrB),
    .readDataA(readDataA),
    .readDataB(readDataB),
    .writeEn(writeEn),
    .writeAddr(writeAddr),
    .writeData(writeData)
  );

  aluCore alu_i (
    .issued(issuedBus.execute),
    .outcome(outcomeBus.produce)
  );

  writebackUnit writeback_i (
    .clk(clk),
    .rstN(rstN),
    .outcome(outcomeBus.retire),
    .writeEn(writeEn),
    .writeAddr(writeAddr),
    .writeData(writeData),
    .carryFlag(carryFlag),
    .resultValid(resultValid),
    .result(result),
    .resultReg(resultReg),
    .resultWritten(resultWritten),
    .flags(flags)
  );

endmodule

// ==== logic/writebackUnit.sv ====
`timescale 1ns/1ps
`include "exec_settings.svh"

module writebackUnit (
  input logic clk,
  input logic rstN,
  resultIf.retire outcome,
  output logic writeEn,
  output logic [`REG_ADDR_WIDTH-1:0] writeAddr,
  output logic [`DATA_WIDTH-1:0] writeData,
  output logic carryFlag,
  output logic resultValid,
  output logic [`DATA_WIDTH-1:0] result,
  output logic [`REG_ADDR_WIDTH-1:0] resultReg,
  output logic resultWritten,
  output execPkg::aluFlags_t flags
);
  import execPkg::*;

  // Register file takes the write on the same edge as the outputs
  assign writeEn = outcome.valid && outcome.writesReg;
  assign writeAddr = outcome.dest;
  assign writeData = outcome.value;

  assign carryFlag = flags.c;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      resultValid <= 1'b0;
      resultWritten <= 1'b0;
      flags <= '0;
    end
    else
    begin
      resultValid <= outcome.valid;
      resultWritten <= writeEn;
      if (outcome.valid)
      begin
        flags <= outcome.flags;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (outcome.valid)
    begin
      result <= outcome.value;
      resultReg <= outcome.dest;
    end
  end

  writtenIsValid: assert property (
    @(posedge clk) disable iff (!rstN)
    resultWritten |-> resultValid
  );

endmodule

// ==== logic/aluCore.sv ====
`timescale 1ns/1ps
`include "exec_settings.svh"

module aluCore (
  operandIf.execute issued,
  resultIf.produce outcome
);
  import execPkg::*;

  logic [`DATA_WIDTH-1:0] a;
  logic [`DATA_WIDTH-1:0] b;
  logic [`DATA_WIDTH-1:0] addX;
  logic [`DATA_WIDTH-1:0] addY;
  logic addCin;
  logic isArith;
  logic [`DATA_WIDTH:0] sum;
  logic [`DATA_WIDTH-1:0] logicValue;
  logic [`DATA_WIDTH-1:0] value;
  aluFlags_t flagsNext;

  assign a = issued.operandA;
  assign b = issued.operandB;

  // Every arithmetic op is x + y + cin; subtraction inverts one side
  always_comb
  begin
    addX = a;
    addY = b;
    addCin = 1'b0;
    isArith = 1'b1;
    case (issued.op)
      OP_ADD, OP_CMN:
      begin
        addCin = 1'b0;
      end
      OP_ADC:
      begin
        addCin = issued.carryIn;
      end
      OP_SUB, OP_CMP:
      begin
        addY = ~b;
        addCin = 1'b1;
      end
      OP_SBC:
      begin
        addY = ~b;
        addCin = issued.carryIn;
      end
      OP_RSB:
      begin
        addX = b;
        addY = ~a;
        addCin = 1'b1;
      end
      OP_RSC:
      begin
        addX = b;
        addY = ~a;
        addCin = issued.carryIn;
      end
      default:
      begin
        isArith = 1'b0;
      end
    endcase
  end

  // Carry out doubles as the inverted borrow for subtraction
  assign sum = {1'b0, addX} + {1'b0, addY} + {{`DATA_WIDTH{1'b0}}, addCin};

  always_comb
  begin
    case (issued.op)
      OP_AND, OP_TST: logicValue = a & b;
      OP_EOR, OP_TEQ: logicValue = a ^ b;
      OP_ORR: logicValue = a | b;
      OP_MOV: logicValue = b;
      OP_BIC: logicValue = a & ~b;
      OP_MVN: logicValue = ~b;
      default: logicValue = '0;
    endcase
  end

  assign value = isArith ? sum[`DATA_WIDTH-1:0] : logicValue;

  always_comb
  begin
    flagsNext.n = value[`DATA_WIDTH-1];
    flagsNext.z = (value == '0);
    flagsNext.c = isArith ? sum[`DATA_WIDTH] : issued.carryIn;
    // Same-sign inputs giving a result of the other sign
    flagsNext.v = isArith && (addX[`DATA_WIDTH-1] == addY[`DATA_WIDTH-1]) &&
                  (value[`DATA_WIDTH-1] != addX[`DATA_WIDTH-1]);
  end

  assign outcome.valid = issued.valid;
  assign outcome.value = value;
  assign outcome.dest = issued.dest;
  assign outcome.writesReg = issued.writesReg;
  assign outcome.flags = flagsNext;

  // Opcode comes registered from the decoder
  always_comb
  begin
    if (issued.valid)
    begin
      opKnown: assert (!$isunknown(issued.op));
    end
  end

endmodule

// ==== logic/registerFile.sv ====
`timescale 1ns/1ps
`include "exec_settings.svh"

module registerFile (
  input logic clk,
  input logic rstN,
  input logic [`REG_ADDR_WIDTH-1:0] readAddrA,
  input logic [`REG_ADDR_WIDTH-1:0] readAddrB,
  output logic [`DATA_WIDTH-1:0] readDataA,
  output logic [`DATA_WIDTH-1:0] readDataB,
  input logic writeEn,
  input logic [`REG_ADDR_WIDTH-1:0] writeAddr,
  input logic [`DATA_WIDTH-1:0] writeData
);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  // Reads see the old value during a same-cycle write
  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (writeEn)
    begin
      regs[writeAddr] <= writeData;
    end
  end

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps
`include "exec_settings.svh"

module instrDecoder (
  input logic clk,
  input logic rstN,
  input logic instrValid,
  input execPkg::instrWord_t instr,
  output logic [`REG_ADDR_WIDTH-1:0] readAddrA,
  output logic [`REG_ADDR_WIDTH-1:0] readAddrB,
  input logic [`DATA_WIDTH-1:0] readDataA,
  input logic [`DATA_WIDTH-1:0] readDataB,
  input logic carryFlag,
  operandIf.issue issued,
  resultIf.forward inFlight
);
  import execPkg::*;

  logic isImm;
  logic classOk;
  logic accept;
  logic compareOnly;
  logic hitA;
  logic hitB;
  logic carrySel;
  logic [`DATA_WIDTH-1:0] opA;
  logic [`DATA_WIDTH-1:0] opB;

  // Only the two data-processing classes are issued
  assign isImm = (instr.immForm.cls == CLASS_IMM);
  assign classOk = isImm || (instr.regForm.cls == CLASS_REG);
  assign accept = instrValid && classOk;

  assign readAddrA = instr.immForm.rn;
  assign readAddrB = instr.regForm.rm;

  // Older instruction still in the ALU has not reached the register file
  assign hitA = inFlight.valid && inFlight.writesReg && (inFlight.dest == readAddrA);
  assign hitB = inFlight.valid && inFlight.writesReg && (inFlight.dest == readAddrB) && !isImm;

  assign opA = hitA ? inFlight.value : readDataA;

  always_comb
  begin
    if (isImm)
    begin
      opB = {{(`DATA_WIDTH - `IMM_WIDTH){1'b0}}, instr.immForm.imm};
    end
    else if (hitB)
    begin
      opB = inFlight.value;
    end
    else
    begin
      opB = readDataB;
    end
  end

  // Flags of any valid older result are newer than the stored carry
  assign carrySel = inFlight.valid ? inFlight.flags.c : carryFlag;

  assign compareOnly = instr.immForm.opcode inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      issued.valid <= 1'b0;
    end
    else
    begin
      issued.valid <= accept;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      issued.op <= instr.immForm.opcode;
      issued.operandA <= opA;
      issued.operandB <= opB;
      issued.carryIn <= carrySel;
      issued.dest <= instr.immForm.rd;
      issued.writesReg <= !compareOnly;
    end
  end

  issueFollowsStrobe: assert property (
    @(posedge clk) disable iff (!rstN)
    $rose(issued.valid) |-> $past(instrValid)
  );

endmodule

// ==== logic/resultIf.sv ====
`timescale 1ns/1ps
`include "exec_settings.svh"

interface resultIf;
  import execPkg::*;

  logic valid;
  logic [`DATA_WIDTH-1:0] value;
  logic [`REG_ADDR_WIDTH-1:0] dest;
  logic writesReg;
  aluFlags_t flags;

  modport produce (output valid, value, dest, writesReg, flags);

  modport retire (input valid, value, dest, writesReg, flags);

  // Decoder side, for bypassing the in-flight result
  modport forward (input valid, value, dest, writesReg, flags);

endinterface

// ==== logic/operandIf.sv ====
`timescale 1ns/1ps
`include "exec_settings.svh"

interface operandIf;
  import execPkg::*;

  logic valid;
  aluOp_t op;
  logic [`DATA_WIDTH-1:0] operandA;
  logic [`DATA_WIDTH-1:0] operandB;
  logic carryIn;
  logic [`REG_ADDR_WIDTH-1:0] dest;
  logic writesReg;

  modport issue (output valid, op, operandA, operandB, carryIn, dest, writesReg);

  modport execute (input valid, op, operandA, operandB, carryIn, dest, writesReg);

endinterface

// ==== logic/execPkg.sv ====
`include "exec_settings.svh"

package execPkg;

  typedef enum logic [2:0]
  {
    CLASS_REG = 3'b000,
    CLASS_IMM = 3'b001
  } instrClass_t;

  // Data-processing opcodes, bits 24..21
  typedef enum logic [3:0]
  {
    OP_AND, OP_EOR, OP_SUB, OP_RSB,
    OP_ADD, OP_ADC, OP_SBC, OP_RSC,
    OP_TST, OP_TEQ, OP_CMP, OP_CMN,
    OP_ORR, OP_MOV, OP_BIC, OP_MVN
  } aluOp_t;

  // Second operand is an 8-bit immediate
  typedef struct packed
  {
    logic [3:0] cond;
    instrClass_t cls;
    aluOp_t opcode;
    logic setFlags;
    logic [`REG_ADDR_WIDTH-1:0] rn;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [3:0] rotate;
    logic [`IMM_WIDTH-1:0] imm;
  } immForm_t;

  // Second operand is register Rm
  typedef struct packed
  {
    logic [3:0] cond;
    instrClass_t cls;
    aluOp_t opcode;
    logic setFlags;
    logic [`REG_ADDR_WIDTH-1:0] rn;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [7:0] spare;
    logic [`REG_ADDR_WIDTH-1:0] rm;
  } regForm_t;

  typedef union packed
  {
    immForm_t immForm;
    regForm_t regForm;
  } instrWord_t;

  typedef struct packed
  {
    logic n;
    logic z;
    logic c;
    logic v;
  } aluFlags_t;

endpackage

// ==== logic/exec_settings.svh ====
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Datapath width of operands and results
`define DATA_WIDTH 32

// Register file size
`define REG_COUNT 16
`define REG_ADDR_WIDTH 4

// Immediate field of the immediate-form instruction
`define IMM_WIDTH 8

// Cycles from a sampled strobe to resultValid
`define RESULT_LATENCY 2

`endif
